// File: design/rvj1_pkg.sv
// rvj1 shared definitions
// Widths, word types, RV32I opcode and funct encodings, ALU and LSU command codes

`default_nettype none

package rvj1_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths and word types
  ////////////////////////////////////////////////////////////////////////////
  localparam int XLEN  = 32;  // Data and instruction width
  localparam int RALEN = 5;   // Register index width

  typedef logic [XLEN-1:0]  word_t;      // Data, immediate or PC
  typedef logic [RALEN-1:0] reg_addr_t;  // x0..x31

  ////////////////////////////////////////////////////////////////////////////
  // Instruction encodings
  ////////////////////////////////////////////////////////////////////////////
  typedef enum logic [6:0] {
    OPCODE_LOAD   = 7'b0000011,
    OPCODE_FENCE  = 7'b0001111,  // Retires as no-op
    OPCODE_OPIMM  = 7'b0010011,
    OPCODE_AUIPC  = 7'b0010111,
    OPCODE_STORE  = 7'b0100011,
    OPCODE_OP     = 7'b0110011,
    OPCODE_LUI    = 7'b0110111,
    OPCODE_BRANCH = 7'b1100011,  // Not executed here
    OPCODE_JALR   = 7'b1100111,  // Not executed here
    OPCODE_JAL    = 7'b1101111,
    OPCODE_SYSTEM = 7'b1110011   // No CSRs, no-op
  } opcode_e;

  // Arithmetic group funct3, shared by OP and OP-IMM
  typedef enum logic [2:0] {
    F3_ADDI      = 3'b000,  // Also ADD/SUB
    F3_SLLI      = 3'b001,
    F3_SLTI      = 3'b010,
    F3_SLTIU     = 3'b011,
    F3_XORI      = 3'b100,
    F3_SRLI_SRAI = 3'b101,
    F3_ORI       = 3'b110,
    F3_ANDI      = 3'b111
  } f3_imm_e;

  // funct7 picks the alternate form
  typedef enum logic [6:0] {
    F7_SLLI_SRLI_ADDI = 7'b0000000,
    F7_SRAI_SUB       = 7'b0100000
  } f7_shift_imm_e;

  ////////////////////////////////////////////////////////////////////////////
  // Execution control codes
  ////////////////////////////////////////////////////////////////////////////
  typedef enum logic [3:0] {
    ALU_OP_ADD,
    ALU_OP_SUB,
    ALU_OP_SLL,
    ALU_OP_SLT,
    ALU_OP_SLTU,
    ALU_OP_XOR,
    ALU_OP_SRL,
    ALU_OP_SRA,
    ALU_OP_OR,
    ALU_OP_AND
  } alu_op_e;

  // Write flag in bit 3, funct3 below it
  typedef enum logic [3:0] {
    LSU_LOAD_BYTE    = 4'b0000,
    LSU_LOAD_HALF    = 4'b0001,
    LSU_LOAD_WORD    = 4'b0010,
    LSU_LOAD_BYTE_U  = 4'b0100,
    LSU_LOAD_HALF_U  = 4'b0101,
    LSU_STORE_BYTE   = 4'b1000,
    LSU_STORE_HALF   = 4'b1001,
    LSU_STORE_WORD   = 4'b1010,
    LSU_NO_CMD       = 4'b1111  // Idle encoding
  } lsu_ctrl_e;

endpackage

`default_nettype wire

// File: design/rvj1_dec_if.sv
// Decode bundle between decoder and execute stage
// Registered control word, one issued pulse per accepted instruction

`timescale 1ns/1ps
`default_nettype none

interface rvj1_dec_if import rvj1_pkg::*; ();

  logic       issued;     // One cycle per accepted instruction
  reg_addr_t  rs1;
  reg_addr_t  rs2;
  alu_op_e    alu_sel;
  logic       a_is_pc;    // ALU A from PC instead of rs1
  logic       b_is_imm;   // ALU B from imm instead of rs2
  logic       write_rf;
  reg_addr_t  rd;
  word_t      imm;        // Already sign extended
  logic       lsu_valid;
  lsu_ctrl_e  lsu_cmd;
  logic       jump;       // JAL

  modport dec (
    output issued, rs1, rs2, alu_sel, a_is_pc, b_is_imm,
    output write_rf, rd, imm, lsu_valid, lsu_cmd, jump
  );

  modport exe (
    input issued, rs1, rs2, alu_sel, a_is_pc, b_is_imm,
    input write_rf, rd, imm, lsu_valid, lsu_cmd, jump
  );

endinterface

`default_nettype wire

// File: design/rvj1_dec.sv
// rvj1 instruction decoder
// Accepts RV32I words on a valid/ready port, registers the control bundle
// for the execute stage. Stall holds the bundle, idle cycles clear it

`timescale 1ns/1ps
`default_nettype none

module rvj1_dec import rvj1_pkg::*; (
  input  logic    clk_i,
  input  logic    rstn_i,
  input  word_t   instr_i,
  input  logic    instr_valid_i,
  input  logic    stall_i,
  output logic    instr_ready_o,
  rvj1_dec_if.dec dec_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Fields and immediates
  ////////////////////////////////////////////////////////////////////////////
  logic       instr_fire;
  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_addr_t  rd_fld, rs1_fld, rs2_fld;
  word_t      imm_i, imm_s, imm_u, imm_j;
  logic       alt_op;  // SUB or SRA form

  assign opcode  = opcode_e'(instr_i[6:0]);
  assign rd_fld  = instr_i[11:7];
  assign funct3  = instr_i[14:12];
  assign rs1_fld = instr_i[19:15];
  assign rs2_fld = instr_i[24:20];
  assign funct7  = instr_i[31:25];

  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

  // funct7 only counts for OP and for right shifts, ADDI imm bits must not make a SUB
  assign alt_op = (funct7 == F7_SRAI_SUB) &&
                  ((opcode == OPCODE_OP) || (funct3 == F3_SRLI_SRAI));

  ////////////////////////////////////////////////////////////////////////////
  // Encoding maps
  ////////////////////////////////////////////////////////////////////////////
  function automatic alu_op_e alu_op_map(input f3_imm_e f3, input logic alt);
    alu_op_e op;
    op = ALU_OP_ADD;
    case (f3)
      F3_ADDI:      op = alt ? ALU_OP_SUB : ALU_OP_ADD;
      F3_SLLI:      op = ALU_OP_SLL;
      F3_SLTI:      op = ALU_OP_SLT;
      F3_SLTIU:     op = ALU_OP_SLTU;
      F3_XORI:      op = ALU_OP_XOR;
      F3_SRLI_SRAI: op = alt ? ALU_OP_SRA : ALU_OP_SRL;
      F3_ORI:       op = ALU_OP_OR;
      F3_ANDI:      op = ALU_OP_AND;
      default:      op = ALU_OP_ADD;
    endcase
    return op;
  endfunction

  function automatic lsu_ctrl_e lsu_cmd_map(input logic [2:0] f3, input logic is_write);
    return lsu_ctrl_e'({is_write, f3});
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Next bundle, no-op unless an instruction is taken
  ////////////////////////////////////////////////////////////////////////////
  reg_addr_t rs1_d, rs2_d, rd_d;
  alu_op_e   alu_sel_d;
  logic      a_is_pc_d, b_is_imm_d, write_rf_d, lsu_valid_d, jump_d;
  word_t     imm_d;
  lsu_ctrl_e lsu_cmd_d;

  assign instr_ready_o = ~stall_i;
  assign instr_fire    = instr_valid_i & instr_ready_o;

  always_comb begin
    rs1_d       = '0;  // x0 reads as zero, LUI relies on it
    rs2_d       = '0;
    rd_d        = '0;
    alu_sel_d   = ALU_OP_ADD;
    a_is_pc_d   = 1'b0;
    b_is_imm_d  = 1'b0;
    write_rf_d  = 1'b0;
    imm_d       = '0;
    lsu_valid_d = 1'b0;
    lsu_cmd_d   = LSU_NO_CMD;
    jump_d      = 1'b0;
    if (instr_fire) begin
      case (opcode)
        OPCODE_OPIMM: begin
          rs1_d      = rs1_fld;
          alu_sel_d  = alu_op_map(f3_imm_e'(funct3), alt_op);
          b_is_imm_d = 1'b1;
          write_rf_d = 1'b1;
          rd_d       = rd_fld;
          imm_d      = imm_i;
        end
        OPCODE_OP: begin
          rs1_d      = rs1_fld;
          rs2_d      = rs2_fld;
          alu_sel_d  = alu_op_map(f3_imm_e'(funct3), alt_op);
          write_rf_d = 1'b1;
          rd_d       = rd_fld;
        end
        OPCODE_LUI, OPCODE_AUIPC: begin  // 0 + imm or pc + imm
          a_is_pc_d  = (opcode == OPCODE_AUIPC);
          b_is_imm_d = 1'b1;
          write_rf_d = 1'b1;
          rd_d       = rd_fld;
          imm_d      = imm_u;
        end
        OPCODE_STORE: begin
          rs1_d       = rs1_fld;
          rs2_d       = rs2_fld;  // Store data
          b_is_imm_d  = 1'b1;
          imm_d       = imm_s;
          lsu_valid_d = 1'b1;
          lsu_cmd_d   = lsu_cmd_map(funct3, 1'b1);
        end
        OPCODE_LOAD: begin
          rs1_d       = rs1_fld;
          b_is_imm_d  = 1'b1;
          imm_d       = imm_i;
          rd_d        = rd_fld;    // Load data never returns, no write
          lsu_valid_d = 1'b1;
          lsu_cmd_d   = lsu_cmd_map(funct3, 1'b0);
        end
        OPCODE_JAL: begin
          a_is_pc_d  = 1'b1;  // ALU gives the target
          b_is_imm_d = 1'b1;
          imm_d      = imm_j;
          write_rf_d = 1'b1;  // Link value pc+4
          rd_d       = rd_fld;
          jump_d     = 1'b1;
        end
        default: ;  // BRANCH, JALR, SYSTEM, FENCE retire as no-op
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bundle registers
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      dec_o.issued    <= 1'b0;
      dec_o.write_rf  <= 1'b0;
      dec_o.lsu_valid <= 1'b0;
      dec_o.jump      <= 1'b0;
    end else begin
      dec_o.issued <= instr_fire;  // Never held through a stall
      if (instr_ready_o) begin
        dec_o.write_rf  <= write_rf_d;
        dec_o.lsu_valid <= lsu_valid_d;
        dec_o.jump      <= jump_d;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (instr_ready_o) begin  // Hold on stall
      dec_o.rs1      <= rs1_d;
      dec_o.rs2      <= rs2_d;
      dec_o.rd       <= rd_d;
      dec_o.alu_sel  <= alu_sel_d;
      dec_o.a_is_pc  <= a_is_pc_d;
      dec_o.b_is_imm <= b_is_imm_d;
      dec_o.imm      <= imm_d;
      dec_o.lsu_cmd  <= lsu_cmd_d;
    end
  end

endmodule

`default_nettype wire

// File: design/rvj1_regfile.sv
// rvj1 integer register file
// 31 writable words, two combinational reads, one write port, x0 fixed at zero

`timescale 1ns/1ps
`default_nettype none

module rvj1_regfile import rvj1_pkg::*; (
  input  logic      clk_i,
  input  logic      rstn_i,
  input  reg_addr_t ra_addr_i,
  input  reg_addr_t rb_addr_i,
  output word_t     ra_data_o,
  output word_t     rb_data_o,
  input  logic      we_i,
  input  reg_addr_t wa_addr_i,
  input  word_t     wd_data_i
);

  localparam int NREGS = 2**RALEN;

  word_t regs_q [1:NREGS-1];  // No storage behind x0

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      for (int i = 1; i < NREGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (wa_addr_i != '0)) begin  // x0 writes dropped
      regs_q[wa_addr_i] <= wd_data_i;
    end
  end

  // Write lands at the edge, readers in the next cycle see it
  assign ra_data_o = (ra_addr_i == '0) ? '0 : regs_q[ra_addr_i];
  assign rb_data_o = (rb_addr_i == '0) ? '0 : regs_q[rb_addr_i];

endmodule

`default_nettype wire

// File: design/rvj1_alu.sv
// rvj1 ALU
// Combinational, the ten RV32I integer operations

`timescale 1ns/1ps
`default_nettype none

module rvj1_alu import rvj1_pkg::*; (
  input  alu_op_e op_i,
  input  word_t   a_i,
  input  word_t   b_i,
  output word_t   res_o
);

  logic [4:0] shamt;  // Low 5 bits only
  logic       lt_s, lt_u;

  assign shamt = b_i[4:0];
  assign lt_s  = $signed(a_i) < $signed(b_i);
  assign lt_u  = a_i < b_i;

  always_comb begin
    case (op_i)
      ALU_OP_ADD:  res_o = a_i + b_i;
      ALU_OP_SUB:  res_o = a_i - b_i;
      ALU_OP_SLL:  res_o = a_i << shamt;
      ALU_OP_SLT:  res_o = {{(XLEN-1){1'b0}}, lt_s};  // 0 or 1
      ALU_OP_SLTU: res_o = {{(XLEN-1){1'b0}}, lt_u};
      ALU_OP_XOR:  res_o = a_i ^ b_i;
      ALU_OP_SRL:  res_o = a_i >> shamt;
      ALU_OP_SRA:  res_o = word_t'($signed(a_i) >>> shamt);  // Sign fill
      ALU_OP_OR:   res_o = a_i | b_i;
      ALU_OP_AND:  res_o = a_i & b_i;
      default:     res_o = a_i + b_i;
    endcase
  end

endmodule

`default_nettype wire

// File: design/rvj1_exec.sv
// rvj1 execute stage
// Operand select, PC tracking, register writeback, LSU command and JAL redirect.
// Acts only on issued cycles, all outputs registered at that edge

`timescale 1ns/1ps
`default_nettype none

module rvj1_exec import rvj1_pkg::*; #(
  parameter word_t BOOT_PC = 32'h0
) (
  input  logic      clk_i,
  input  logic      rstn_i,
  rvj1_dec_if.exe   dec_i,
  input  word_t     ra_data_i,
  input  word_t     rb_data_i,
  // ALU
  output alu_op_e   alu_op_o,
  output word_t     alu_a_o,
  output word_t     alu_b_o,
  input  word_t     alu_res_i,
  // Register file write
  output logic      rf_we_o,
  output reg_addr_t rf_waddr_o,
  output word_t     rf_wdata_o,
  // Retire
  output logic      retire_valid_o,
  output logic      rd_we_o,
  output reg_addr_t rd_addr_o,
  output word_t     rd_data_o,
  output word_t     retire_pc_o,
  // LSU command
  output logic      lsu_valid_o,
  output lsu_ctrl_e lsu_cmd_o,
  output word_t     lsu_addr_o,
  output word_t     lsu_wdata_o,
  // Redirect
  output logic      redirect_valid_o,
  output word_t     redirect_pc_o
);

  word_t pc_q;      // Architectural PC
  word_t pc_plus4;
  word_t wb_data;
  logic  wb_en;

  assign alu_op_o = dec_i.alu_sel;
  assign alu_a_o  = dec_i.a_is_pc  ? pc_q      : ra_data_i;
  assign alu_b_o  = dec_i.b_is_imm ? dec_i.imm : rb_data_i;

  assign pc_plus4 = pc_q + 32'd4;
  assign wb_data  = dec_i.jump ? pc_plus4 : alu_res_i;  // JAL links
  assign wb_en    = dec_i.issued && dec_i.write_rf && (dec_i.rd != '0);

  assign rf_we_o    = wb_en;
  assign rf_waddr_o = dec_i.rd;
  assign rf_wdata_o = wb_data;

  ////////////////////////////////////////////////////////////////////////////
  // PC and output valids
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      pc_q             <= BOOT_PC;
      retire_valid_o   <= 1'b0;
      rd_we_o          <= 1'b0;
      lsu_valid_o      <= 1'b0;
      redirect_valid_o <= 1'b0;
    end else begin
      retire_valid_o   <= dec_i.issued;  // One pulse per instruction
      rd_we_o          <= wb_en;
      lsu_valid_o      <= dec_i.issued & dec_i.lsu_valid;
      redirect_valid_o <= dec_i.issued & dec_i.jump;
      if (dec_i.issued) begin
        pc_q <= dec_i.jump ? alu_res_i : pc_plus4;  // JAL target is pc+imm
      end
    end
  end

  // Payload, only meaningful alongside its valid
  always_ff @(posedge clk_i) begin
    if (dec_i.issued) begin
      rd_addr_o     <= dec_i.rd;
      rd_data_o     <= wb_data;
      retire_pc_o   <= pc_q;
      lsu_cmd_o     <= dec_i.lsu_cmd;
      lsu_addr_o    <= alu_res_i;  // rs1 + imm
      lsu_wdata_o   <= rb_data_i;
      redirect_pc_o <= alu_res_i;
    end
  end

endmodule

`default_nettype wire

// File: design/rvj1_core.sv
// rvj1 execution slice top level
// Decoder, register file, ALU and execute stage, plain ports to the outside

`timescale 1ns/1ps
`default_nettype none

module rvj1_core import rvj1_pkg::*; #(
  parameter word_t BOOT_PC = 32'h0
) (
  input  logic      clk_i,
  input  logic      rstn_i,
  // Instruction port
  input  word_t     instr_i,
  input  logic      instr_valid_i,
  input  logic      stall_i,
  output logic      instr_ready_o,
  // Retire
  output logic      retire_valid_o,
  output logic      rd_we_o,
  output reg_addr_t rd_addr_o,
  output word_t     rd_data_o,
  output word_t     retire_pc_o,
  // LSU command
  output logic      lsu_valid_o,
  output lsu_ctrl_e lsu_cmd_o,
  output word_t     lsu_addr_o,
  output word_t     lsu_wdata_o,
  // Redirect
  output logic      redirect_valid_o,
  output word_t     redirect_pc_o
);

  rvj1_dec_if dec_bus ();

  word_t     ra_data, rb_data;
  alu_op_e   alu_op;
  word_t     alu_a, alu_b, alu_res;
  logic      rf_we;
  reg_addr_t rf_waddr;
  word_t     rf_wdata;

  rvj1_dec u_dec (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .instr_i       (instr_i),
    .instr_valid_i (instr_valid_i),
    .stall_i       (stall_i),
    .instr_ready_o (instr_ready_o),
    .dec_o         (dec_bus.dec)
  );

  // Read addresses come straight from the bundle
  rvj1_regfile u_regfile (
    .clk_i     (clk_i),
    .rstn_i    (rstn_i),
    .ra_addr_i (dec_bus.rs1),
    .rb_addr_i (dec_bus.rs2),
    .ra_data_o (ra_data),
    .rb_data_o (rb_data),
    .we_i      (rf_we),
    .wa_addr_i (rf_waddr),
    .wd_data_i (rf_wdata)
  );

  rvj1_alu u_alu (
    .op_i  (alu_op),
    .a_i   (alu_a),
    .b_i   (alu_b),
    .res_o (alu_res)
  );

  rvj1_exec #(
    .BOOT_PC (BOOT_PC)
  ) u_exec (
    .clk_i            (clk_i),
    .rstn_i           (rstn_i),
    .dec_i            (dec_bus.exe),
    .ra_data_i        (ra_data),
    .rb_data_i        (rb_data),
    .alu_op_o         (alu_op),
    .alu_a_o          (alu_a),
    .alu_b_o          (alu_b),
    .alu_res_i        (alu_res),
    .rf_we_o          (rf_we),
    .rf_waddr_o       (rf_waddr),
    .rf_wdata_o       (rf_wdata),
    .retire_valid_o   (retire_valid_o),
    .rd_we_o          (rd_we_o),
    .rd_addr_o        (rd_addr_o),
    .rd_data_o        (rd_data_o),
    .retire_pc_o      (retire_pc_o),
    .lsu_valid_o      (lsu_valid_o),
    .lsu_cmd_o        (lsu_cmd_o),
    .lsu_addr_o       (lsu_addr_o),
    .lsu_wdata_o      (lsu_wdata_o),
    .redirect_valid_o (redirect_valid_o),
    .redirect_pc_o    (redirect_pc_o)
  );

endmodule

`default_nettype wire

// File: tests/rvj1_checker.sv
// rvj1 protocol checker
// Concurrent assertions on handshake, retire timing and output rules

`timescale 1ns/1ps
`default_nettype none

module rvj1_checker import rvj1_pkg::*; (
  input logic      clk_i,
  input logic      rstn_i,
  input logic      instr_valid_i,
  input logic      stall_i,
  input logic      instr_ready_o,
  input logic      retire_valid_o,
  input logic      rd_we_o,
  input reg_addr_t rd_addr_o,
  input logic      lsu_valid_o,
  input logic      redirect_valid_o
);

  int   fail_cnt = 0;  // Failed assertion count
  logic fire;

  assign fire = instr_valid_i & instr_ready_o;

  a_ready_stall: assert property (@(posedge clk_i) instr_ready_o == !stall_i)
    else begin
      fail_cnt++;
      $error("instr_ready_o is not the inverse of stall_i");
    end

  a_no_x0_write: assert property (@(posedge clk_i) disable iff (!rstn_i)
    rd_we_o |-> (rd_addr_o != '0))
    else begin
      fail_cnt++;
      $error("rd_we_o high with rd_addr_o zero");
    end

  a_lsu_no_write: assert property (@(posedge clk_i) disable iff (!rstn_i)
    !(lsu_valid_o && rd_we_o))
    else begin
      fail_cnt++;
      $error("lsu_valid_o and rd_we_o high together");
    end

  a_redirect_retire: assert property (@(posedge clk_i) disable iff (!rstn_i)
    redirect_valid_o |-> retire_valid_o)
    else begin
      fail_cnt++;
      $error("redirect_valid_o without retire_valid_o");
    end

  // Retire follows acceptance by exactly two edges
  a_retire_latency: assert property (@(posedge clk_i) disable iff (!rstn_i)
    retire_valid_o == $past(fire, 2))
    else begin
      fail_cnt++;
      $error("retire_valid_o not two edges after acceptance");
    end

endmodule

bind rvj1_core rvj1_checker chk (
  .clk_i            (clk_i),
  .rstn_i           (rstn_i),
  .instr_valid_i    (instr_valid_i),
  .stall_i          (stall_i),
  .instr_ready_o    (instr_ready_o),
  .retire_valid_o   (retire_valid_o),
  .rd_we_o          (rd_we_o),
  .rd_addr_o        (rd_addr_o),
  .lsu_valid_o      (lsu_valid_o),
  .redirect_valid_o (redirect_valid_o)
);

`default_nettype wire

// File: tests/rvj1_monitor.sv
// rvj1 retire monitor
// Compares each retire cycle against the oldest expected record

`timescale 1ns/1ps
`default_nettype none

module rvj1_monitor import rvj1_pkg::*; (
  input  logic      clk_i,
  input  logic      rstn_i,
  input  logic      retire_valid_i,
  input  logic      rd_we_i,
  input  reg_addr_t rd_addr_i,
  input  word_t     rd_data_i,
  input  word_t     retire_pc_i,
  input  logic      lsu_valid_i,
  input  lsu_ctrl_e lsu_cmd_i,
  input  word_t     lsu_addr_i,
  input  word_t     lsu_wdata_i,
  input  logic      redirect_valid_i,
  input  word_t     redirect_pc_i
);

  typedef struct packed {
    logic       rd_we;
    reg_addr_t  rd;
    word_t      data;
    word_t      pc;
    logic       lsu_v;
    logic [3:0] cmd;    // Bit 3 set for stores
    word_t      addr;
    word_t      wdata;
    logic       redir_v;
    word_t      redir_pc;
  } exp_t;

  exp_t exp_q [$];    // Oldest first
  int   err_cnt = 0;
  int   retired = 0;

  task automatic expect_retire(input logic rd_we, input reg_addr_t rd, input word_t data,
                               input word_t pc, input logic lsu_v, input logic [3:0] cmd,
                               input word_t addr, input word_t wdata, input logic redir_v,
                               input word_t redir_pc);
    exp_t e;
    e.rd_we    = rd_we;
    e.rd       = rd;
    e.data     = data;
    e.pc       = pc;
    e.lsu_v    = lsu_v;
    e.cmd      = cmd;
    e.addr     = addr;
    e.wdata    = wdata;
    e.redir_v  = redir_v;
    e.redir_pc = redir_pc;
    exp_q.push_back(e);
  endtask

  task automatic compare_field(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      err_cnt++;
      $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Outputs change on the rising edge and are sampled mid-cycle
  ////////////////////////////////////////////////////////////////////////////
  always @(negedge clk_i) begin
    exp_t e;
    if (rstn_i && retire_valid_i) begin
      retired++;
      if (exp_q.size() == 0) begin
        err_cnt++;
        $display("Unexpected retire at %0t with pc %h, no instruction outstanding",
                 $time, retire_pc_i);
      end else begin
        e = exp_q.pop_front();
        compare_field("retire_pc_o", retire_pc_i, e.pc);
        compare_field("rd_we_o", word_t'(rd_we_i), word_t'(e.rd_we));
        if (e.rd_we) begin  // Payload only with its enable
          compare_field("rd_addr_o", word_t'(rd_addr_i), word_t'(e.rd));
          compare_field("rd_data_o", rd_data_i, e.data);
        end
        compare_field("lsu_valid_o", word_t'(lsu_valid_i), word_t'(e.lsu_v));
        if (e.lsu_v) begin
          compare_field("lsu_cmd_o", word_t'(lsu_cmd_i), word_t'(e.cmd));
          compare_field("lsu_addr_o", lsu_addr_i, e.addr);
          if (e.cmd[3]) compare_field("lsu_wdata_o", lsu_wdata_i, e.wdata);  // Stores
        end
        compare_field("redirect_valid_o", word_t'(redirect_valid_i), word_t'(e.redir_v));
        if (e.redir_v) compare_field("redirect_pc_o", redirect_pc_i, e.redir_pc);
      end
    end else if (rstn_i && (rd_we_i || lsu_valid_i || redirect_valid_i)) begin
      // Side effects only in a retire cycle
      err_cnt++;
      $display("Write, LSU or redirect valid at %0t without retire_valid_o", $time);
    end
  end

endmodule

`default_nettype wire

// File: tests/rvj1_tb.sv
// rvj1 testbench top
// Clock and reset, replays the stim file on the instruction port with stalls
// and random idle gaps, then prints the verdict

`timescale 1ns/1ps
`default_nettype none

module rvj1_tb import rvj1_pkg::*; ();

  localparam word_t BOOT_PC    = 32'h0000_0100;
  localparam int    FIELDS     = 12;   // Hex words per stim record
  localparam int    MAX_REC    = 64;
  localparam int    ACCEPT_TMO = 16;   // Cycles until ready must show
  localparam int    DRAIN_TMO  = 200;  // Cycles for the last retires

  logic      clk;
  logic      rstn;
  word_t     instr;
  logic      instr_valid;
  logic      stall;
  logic      instr_ready;
  logic      retire_valid;
  logic      rd_we;
  reg_addr_t rd_addr;
  word_t     rd_data;
  word_t     retire_pc;
  logic      lsu_valid;
  lsu_ctrl_e lsu_cmd;
  word_t     lsu_addr;
  word_t     lsu_wdata;
  logic      redirect_valid;
  word_t     redirect_pc;

  word_t stim_mem [0:FIELDS*MAX_REC];  // Word 0 holds the record count
  int    tmo_cnt = 0;

  rvj1_core #(
    .BOOT_PC (BOOT_PC)
  ) UUT (
    .clk_i            (clk),
    .rstn_i           (rstn),
    .instr_i          (instr),
    .instr_valid_i    (instr_valid),
    .stall_i          (stall),
    .instr_ready_o    (instr_ready),
    .retire_valid_o   (retire_valid),
    .rd_we_o          (rd_we),
    .rd_addr_o        (rd_addr),
    .rd_data_o        (rd_data),
    .retire_pc_o      (retire_pc),
    .lsu_valid_o      (lsu_valid),
    .lsu_cmd_o        (lsu_cmd),
    .lsu_addr_o       (lsu_addr),
    .lsu_wdata_o      (lsu_wdata),
    .redirect_valid_o (redirect_valid),
    .redirect_pc_o    (redirect_pc)
  );

  rvj1_monitor mon (
    .clk_i            (clk),
    .rstn_i           (rstn),
    .retire_valid_i   (retire_valid),
    .rd_we_i          (rd_we),
    .rd_addr_i        (rd_addr),
    .rd_data_i        (rd_data),
    .retire_pc_i      (retire_pc),
    .lsu_valid_i      (lsu_valid),
    .lsu_cmd_i        (lsu_cmd),
    .lsu_addr_i       (lsu_addr),
    .lsu_wdata_i      (lsu_wdata),
    .redirect_valid_i (redirect_valid),
    .redirect_pc_i    (redirect_pc)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  ////////////////////////////////////////////////////////////////////////////
  // Drivers, entered and left on a falling edge
  ////////////////////////////////////////////////////////////////////////////
  task automatic send_instr(input word_t word, input int stall_cycles);
    int k;
    int waited;
    instr       = word;
    instr_valid = 1'b1;               // Offered during the stall too
    stall       = (stall_cycles > 0);
    for (k = 0; k < stall_cycles; k++) begin
      @(negedge clk);
    end
    stall  = 1'b0;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (!instr_ready && waited < ACCEPT_TMO);
    if (!instr_ready) begin
      tmo_cnt++;
      $display("Timeout at %0t: instruction %h not accepted within %0d cycles",
               $time, word, ACCEPT_TMO);
    end
    @(negedge clk);
    instr_valid = 1'b0;
  endtask

  task automatic idle_gap(input int cycles);
    int k;
    instr_valid = 1'b0;
    for (k = 0; k < cycles; k++) begin
      instr = $urandom;  // Junk with valid low, must be ignored
      @(negedge clk);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    int n_rec;
    int base;
    int r;
    int waited;
    int errs;
    void'($urandom(32'h7d2c_b859));
    instr       = '0;
    instr_valid = 1'b0;
    stall       = 1'b0;
    rstn        = 1'b0;
    $readmemh("tests/rvj1_stim.txt", stim_mem);
    n_rec = int'(stim_mem[0]);

    repeat (2) @(posedge clk);  // Two cycles in reset
    @(negedge clk);
    rstn = 1'b1;

    for (r = 0; r < n_rec; r++) begin
      base = 1 + r * FIELDS;
      // Expected record goes out before the instruction does
      mon.expect_retire(stim_mem[base+2][0], stim_mem[base+3][4:0], stim_mem[base+4],
                        stim_mem[base+5], stim_mem[base+6][0], stim_mem[base+7][3:0],
                        stim_mem[base+8], stim_mem[base+9], stim_mem[base+10][0],
                        stim_mem[base+11]);
      if ($urandom % 4 == 0) begin
        idle_gap(int'(1 + $urandom % 3));
      end
      send_instr(stim_mem[base], int'(stim_mem[base+1]));
    end

    waited = 0;
    while (mon.retired < n_rec && waited < DRAIN_TMO) begin
      @(negedge clk);
      waited++;
    end
    if (mon.retired < n_rec) begin
      tmo_cnt++;
      $display("Timeout at %0t: only %0d of %0d instructions retired",
               $time, mon.retired, n_rec);
    end
    repeat (4) @(negedge clk);  // Room for a stray extra retire

    errs = mon.err_cnt + UUT.chk.fail_cnt + tmo_cnt;
    $display("Errors %0d, assertion failures %0d, timeouts %0d, retired %0d of %0d",
             mon.err_cnt, UUT.chk.fail_cnt, tmo_cnt, mon.retired, n_rec);
    if (errs == 0 && mon.retired == n_rec) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/rvj1_stim.txt
// instr stall rd_we rd data pc lsu_v cmd addr wdata redir_v redir_pc (all hex)
// First word is the record count in hex, then one record per line
24
00500093 0 1 01 00000005 00000100 0 0 00000000 00000000 0 00000000
ffd00113 0 1 02 fffffffd 00000104 0 0 00000000 00000000 0 00000000
002081b3 1 1 03 00000002 00000108 0 0 00000000 00000000 0 00000000
40110233 0 1 04 fffffff8 0000010c 0 0 00000000 00000000 0 00000000
001122b3 0 1 05 00000001 00000110 0 0 00000000 00000000 0 00000000
00113333 0 1 06 00000000 00000114 0 0 00000000 00000000 0 00000000
fff12393 0 1 07 00000001 00000118 0 0 00000000 00000000 0 00000000
fff0b413 2 1 08 00000001 0000011c 0 0 00000000 00000000 0 00000000
0f014493 0 1 09 ffffff0d 00000120 0 0 00000000 00000000 0 00000000
3000e513 0 1 0a 00000305 00000124 0 0 00000000 00000000 0 00000000
07f17593 0 1 0b 0000007d 00000128 0 0 00000000 00000000 0 00000000
00409613 0 1 0c 00000050 0000012c 0 0 00000000 00000000 0 00000000
00425693 0 1 0d 0fffffff 00000130 0 0 00000000 00000000 0 00000000
40225713 0 1 0e fffffffe 00000134 0 0 00000000 00000000 0 00000000
00c097b3 3 1 0f 00050000 00000138 0 0 00000000 00000000 0 00000000
00125833 0 1 10 07ffffff 0000013c 0 0 00000000 00000000 0 00000000
401258b3 0 1 11 ffffffff 00000140 0 0 00000000 00000000 0 00000000
0024c933 0 1 12 000000f0 00000144 0 0 00000000 00000000 0 00000000
00b569b3 0 1 13 0000037d 00000148 0 0 00000000 00000000 0 00000000
0021fa33 0 1 14 00000000 0000014c 0 0 00000000 00000000 0 00000000
00708013 0 0 00 00000000 00000150 0 0 00000000 00000000 0 00000000
00100ab3 1 1 15 00000005 00000154 0 0 00000000 00000000 0 00000000
12345b37 0 1 16 12345000 00000158 0 0 00000000 00000000 0 00000000
00001b97 0 1 17 0000115c 0000015c 0 0 00000000 00000000 0 00000000
001b2423 0 0 00 00000000 00000160 1 a 12345008 00000005 0 00000000
fe2b0e23 2 0 00 00000000 00000164 1 8 12344ffc fffffffd 0 00000000
002b5c03 0 0 00 00000000 00000168 1 5 12345002 00000000 0 00000000
fff08c83 0 0 00 00000000 0000016c 1 0 00000004 00000000 0 00000000
010000ef 0 1 01 00000174 00000170 0 0 00000000 00000000 1 00000180
00008d13 1 1 1a 00000174 00000180 0 0 00000000 00000000 0 00000000
00000073 0 0 00 00000000 00000184 0 0 00000000 00000000 0 00000000
00108463 0 0 00 00000000 00000188 0 0 00000000 00000000 0 00000000
0ff0000f 0 0 00 00000000 0000018c 0 0 00000000 00000000 0 00000000
ff9ff06f 0 0 00 00000000 00000190 0 0 00000000 00000000 1 00000188
004d0db3 2 1 1b 0000016c 00000188 0 0 00000000 00000000 0 00000000
010d8e13 0 1 1c 0000017c 0000018c 0 0 00000000 00000000 0 00000000

// File: files.f
design/rvj1_pkg.sv
design/rvj1_dec_if.sv
design/rvj1_dec.sv
design/rvj1_regfile.sv
design/rvj1_alu.sv
design/rvj1_exec.sv
design/rvj1_core.sv
tests/rvj1_checker.sv
tests/rvj1_monitor.sv
tests/rvj1_tb.sv

// File: Makefile
# Verilator build of the rvj1 testbench, run with a pass check, clean

SRCS := $(shell grep -v '^+' files.f)

.PHONY: run clean

run: obj_dir/Vrvj1_tb
	@out="$$(obj_dir/Vrvj1_tb +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

obj_dir/Vrvj1_tb: files.f $(SRCS)
	verilator --binary --timing --assert --top-module rvj1_tb -f files.f

clean:
	rm -rf obj_dir
